// File: common/shift_pkg.sv
// shift unit package: widths, opcode enum and request/response structs
package shift_pkg;

    // operand width is tied to the 4x8 crossbar
    localparam int data_w = 32;
    localparam int amt_w = 5;
    localparam int tag_w = 4; // matches responses to requests

    typedef enum logic [1:0] {
        OP_SLL = 2'd0,
        OP_SRL = 2'd1,
        OP_SRA = 2'd2
    } shift_op_e;

    // 43 bits
    typedef struct packed {
        shift_op_e          op;
        logic [amt_w-1:0]   amount;
        logic [data_w-1:0]  data;
        logic [tag_w-1:0]   tag;
    } shift_req_t;

    // 36 bits
    typedef struct packed {
        logic [data_w-1:0]  result;
        logic [tag_w-1:0]   tag;
    } shift_rsp_t;

endpackage

// File: shifter/shifter_triangle_8.sv
// 8x8 lower-triangle cell array, shifts a byte left inside its own lane
module shifter_triangle_8 (
    input  logic [7:0] shift,
    input  logic [7:0] datain,
    output logic [7:0] dataout
);

    // bit i collects datain[i-k] on one-hot line k
    always_comb begin
        dataout = '0;
        for (int i = 0; i < 8; i++) begin
            for (int k = 0; k <= i; k++) begin
                dataout[i] = dataout[i] | (shift[k] & datain[i - k]);
            end
        end
    end

endmodule

// File: shifter/shifter_square_8.sv
// 8x8 square cell array, carries a lower byte into a higher lane
module shifter_square_8 (
    input  logic [7:0] shift,   // lines for distance base .. base+7
    input  logic [6:0] shiftin, // lines for distance base-7 .. base-1
    input  logic [7:0] datain,
    output logic [7:0] dataout
);

    // distance from datain[j] to dataout[i] is base + i - j
    always_comb begin
        dataout = '0;
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                if (i >= j) begin
                    dataout[i] = dataout[i] | (shift[i - j] & datain[j]);
                end else begin
                    // short distance, line comes from lower group
                    dataout[i] = dataout[i] | (shiftin[7 + i - j] & datain[j]);
                end
            end
        end
    end

endmodule

// File: shifter/shifter_32.sv
// 32-bit crossbar shifter, left shift with mirroring for right shifts
module shifter_32 (
    input  logic [shift_pkg::amt_w-1:0]  amount,
    input  logic [shift_pkg::data_w-1:0] data,
    input  logic                         right,
    output logic [shift_pkg::data_w-1:0] shifted
);

    logic [shift_pkg::data_w-1:0] lines;   // one-hot shift lines
    logic [shift_pkg::data_w-1:0] operand;
    logic [shift_pkg::data_w-1:0] result;

    function automatic logic [shift_pkg::data_w-1:0] reverse_bits(
        input logic [shift_pkg::data_w-1:0] v
    );
        logic [shift_pkg::data_w-1:0] r;
        for (int i = 0; i < shift_pkg::data_w; i++) begin
            r[i] = v[shift_pkg::data_w - 1 - i];
        end
        return r;
    endfunction

    // 5 to 32 decoder
    always_comb begin
        for (int i = 0; i < shift_pkg::data_w; i++) begin
            lines[i] = (amount == shift_pkg::amt_w'(i));
        end
    end

    assign operand = right ? reverse_bits(data) : data; // mirror in

    // lane dst gathers triangle of its own byte plus squares of lower bytes
    for (genvar dst = 0; dst < 4; dst++) begin : g_dst
        wire [7:0] part [4];

        for (genvar src = 0; src < 4; src++) begin : g_src
            if (src == dst) begin : g_tri
                shifter_triangle_8 u_tri (
                    .shift   (lines[7:0]),
                    .datain  (operand[8*src +: 8]),
                    .dataout (part[src])
                );
            end else if (src < dst) begin : g_sq
                shifter_square_8 u_sq (
                    .shift   (lines[8*(dst-src) +: 8]),
                    .shiftin (lines[8*(dst-src)-7 +: 7]),
                    .datain  (operand[8*src +: 8]),
                    .dataout (part[src])
                );
            end else begin : g_none
                assign part[src] = '0; // higher bytes never move down
            end
        end

        assign result[8*dst +: 8] = part[0] | part[1] | part[2] | part[3];
    end

    assign shifted = right ? reverse_bits(result) : result; // mirror out

endmodule

// File: rtl/fill_mask_gen.sv
// sign-fill mask for the vacated top bits of an arithmetic right shift
module fill_mask_gen (
    input  shift_pkg::shift_op_e         op,
    input  logic [shift_pkg::amt_w-1:0]  amount,
    input  logic                         sign,
    output logic [shift_pkg::data_w-1:0] fill_mask
);

    logic [shift_pkg::data_w-1:0] therm;
    logic                         fill_en;

    // thermometer decode, ones in the top amount bits
    always_comb begin
        for (int i = 0; i < shift_pkg::data_w; i++) begin
            therm[i] = amount > shift_pkg::amt_w'(shift_pkg::data_w - 1 - i);
        end
    end

    assign fill_en = (op == shift_pkg::OP_SRA) && sign;

    // zero for SLL, SRL and positive SRA
    assign fill_mask = fill_en ? therm : '0;

endmodule

// File: rtl/shift_req_fifo.sv
// request queue, returns one upstream credit per issued entry
module shift_req_fifo #(
    parameter int fifo_depth = 4
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  req_valid,
    input  shift_pkg::shift_req_t req,
    output logic                  req_credit,
    input  logic                  issue_ok,
    output logic                  issue_valid,
    output shift_pkg::shift_req_t issue_req
);

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    shift_pkg::shift_req_t mem [fifo_depth];
    logic [ptr_w-1:0]      wr_ptr;
    logic [ptr_w-1:0]      rd_ptr;
    logic [cnt_w-1:0]      count;
    logic                  push;
    logic                  pop;

    // depth need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(fifo_depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign push = req_valid && (count != cnt_w'(fifo_depth));
    assign pop  = (count != '0) && issue_ok;

    assign issue_valid = pop;
    assign req_credit  = pop;   // credit goes back as the entry leaves
    assign issue_req   = mem[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= req;
        end
    end

endmodule

// File: rtl/shift_merge.sv
// merge stage, applies the fill mask, registers the response, counts credits
module shift_merge #(
    parameter int out_credits = 2
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         issue_valid,
    input  logic [shift_pkg::tag_w-1:0]  tag,
    input  logic [shift_pkg::data_w-1:0] shifted,
    input  logic [shift_pkg::data_w-1:0] fill_mask,
    output logic                         issue_ok,
    output logic                         rsp_valid,
    output shift_pkg::shift_rsp_t        rsp,
    input  logic                         rsp_credit
);

    localparam int cred_w = $clog2(out_credits + 1);

    logic [cred_w-1:0] credit_cnt;

    assign issue_ok = (credit_cnt != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= cred_w'(out_credits);
            rsp_valid  <= 1'b0;
        end else begin
            rsp_valid <= issue_valid;
            // spend and return may land together
            case ({issue_valid, rsp_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            rsp.result <= shifted | fill_mask;
            rsp.tag    <= tag;
        end
    end

endmodule

// File: rtl/shift_unit.sv
// shift execution unit top, queue feeding shifter and fill mask into merge
module shift_unit #(
    parameter int fifo_depth = 4,
    parameter int out_credits = 2
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  req_valid,
    input  shift_pkg::shift_req_t req,
    output logic                  req_credit,
    output logic                  rsp_valid,
    output shift_pkg::shift_rsp_t rsp,
    input  logic                  rsp_credit
);

    logic                         issue_ok;
    logic                         issue_valid;
    shift_pkg::shift_req_t        issue_req;
    logic [shift_pkg::data_w-1:0] shifted;
    logic [shift_pkg::data_w-1:0] fill_mask;

    shift_req_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req         (req),
        .req_credit  (req_credit),
        .issue_ok    (issue_ok),
        .issue_valid (issue_valid),
        .issue_req   (issue_req)
    );

    // both paths work on the queue head in the same cycle
    shifter_32 u_shifter (
        .amount  (issue_req.amount),
        .data    (issue_req.data),
        .right   ((issue_req.op == shift_pkg::OP_SRL) || (issue_req.op == shift_pkg::OP_SRA)),
        .shifted (shifted)
    );

    fill_mask_gen u_fill (
        .op        (issue_req.op),
        .amount    (issue_req.amount),
        .sign      (issue_req.data[shift_pkg::data_w-1]),
        .fill_mask (fill_mask)
    );

    shift_merge #(
        .out_credits (out_credits)
    ) u_merge (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .tag         (issue_req.tag),
        .shifted     (shifted),
        .fill_mask   (fill_mask),
        .issue_ok    (issue_ok),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .rsp_credit  (rsp_credit)
    );

endmodule

// File: testbench/tb_shift_unit.sv
// testbench for the shift unit, credit-driven stimulus checked by assertions
module tb_shift_unit;

    localparam int fifo_depth = 4;
    localparam int out_credits = 2;
    localparam int max_req = 256;
    localparam int req_total = 168; // four sweeps of 32 plus 40 under back-pressure
    localparam int cycle_limit = 4 * (req_total * 3 + 100);

    logic                  clk;
    logic                  arst_n;
    logic                  req_valid;
    shift_pkg::shift_req_t req;
    logic                  req_credit;
    logic                  rsp_valid;
    shift_pkg::shift_rsp_t rsp;
    logic                  rsp_credit;

    shift_pkg::shift_rsp_t exp_rsp [max_req];
    string                 test_of [max_req];
    shift_pkg::shift_rsp_t exp_head;

    int   sent_cnt;
    int   credit_cnt;   // req_credit pulses seen
    int   rsp_cnt;
    int   returned_cnt; // rsp_credit pulses given
    int   cycle_cnt;
    int   mismatch_errs;
    int   other_errs;
    logic bp_mode;
    int   stall_left;

    shift_unit #(
        .fifo_depth  (fifo_depth),
        .out_credits (out_credits)
    ) dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req        (req),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_credit (rsp_credit)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (req_credit) begin
            credit_cnt <= credit_cnt + 1;
        end
        if (rsp_valid) begin
            rsp_cnt <= rsp_cnt + 1;
        end
    end

    always_comb begin
        exp_head = (rsp_cnt < max_req) ? exp_rsp[rsp_cnt] : '0;
    end

    // responses in request order, tag included
    assert property (@(posedge clk) disable iff (!arst_n) rsp_valid |-> rsp == exp_head)
    else begin
        mismatch_errs++;
        $display("Mismatch %s: expected %h actual %h", test_of[$sampled(rsp_cnt)],
                 $sampled(exp_head), $sampled(rsp));
    end

    assert property (@(posedge clk) disable iff (!arst_n) rsp_valid |-> rsp_cnt < sent_cnt)
    else begin
        other_errs++;
        $display("response arrived with no request outstanding");
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> (out_credits + returned_cnt - rsp_cnt) > 0)
    else begin
        other_errs++;
        $display("response sent without a downstream credit");
    end

    assert property (@(posedge clk) disable iff (!arst_n) rsp_valid |-> credit_cnt > rsp_cnt)
    else begin
        other_errs++;
        $display("response came out before its upstream credit was returned");
    end

    assert property (@(posedge clk) disable iff (!arst_n) req_credit |-> credit_cnt < sent_cnt)
    else begin
        other_errs++;
        $display("upstream credit returned with no request in the queue");
    end

    // quiet from reset until the first request
    assert property (@(posedge clk) disable iff (!arst_n)
        (sent_cnt == 0) |-> (!req_credit && !rsp_valid))
    else begin
        other_errs++;
        $display("req_credit or rsp_valid high before any request was sent");
    end

    // downstream credits, long stalls in back-pressure mode
    always @(posedge clk) begin
        #1;
        rsp_credit = 1'b0;
        if (!bp_mode) begin
            stall_left = 0;
        end
        if (bp_mode && stall_left > 0) begin
            stall_left--;
        end else if (rsp_cnt > returned_cnt && ($urandom % 4) != 0) begin
            rsp_credit = 1'b1;
            returned_cnt++;
            if (bp_mode && ($urandom % 3) == 0) begin
                stall_left = 10 + $urandom % 20;
            end
        end
    end

    task automatic print_error_counts;
        $display("error counts: %0d mismatch, %0d other", mismatch_errs, other_errs);
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            other_errs++;
            $display("timeout after %0d cycles with %0d of %0d responses seen",
                     cycle_cnt, rsp_cnt, sent_cnt);
            print_error_counts();
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // waits for an upstream credit, then sends one request
    task automatic send_req(input shift_pkg::shift_op_e op, input int amount,
                            input logic [31:0] data, input string name);
        logic [31:0] expect_val;
        logic [4:0]  amt;
        amt = shift_pkg::amt_w'(amount);
        while (sent_cnt - credit_cnt >= fifo_depth) begin
            req_valid = 1'b0;
            @(posedge clk);
            #1;
        end
        case (op)
            shift_pkg::OP_SLL: expect_val = data << amt;
            shift_pkg::OP_SRL: expect_val = data >> amt;
            default:           expect_val = $signed(data) >>> amt;
        endcase
        exp_rsp[sent_cnt].result = expect_val;
        exp_rsp[sent_cnt].tag = shift_pkg::tag_w'(sent_cnt);
        test_of[sent_cnt] = name;
        req.op = op;
        req.amount = amt;
        req.data = data;
        req.tag = shift_pkg::tag_w'(sent_cnt);
        req_valid = 1'b1;
        sent_cnt++;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    initial begin
        shift_pkg::shift_op_e op;
        void'($urandom(32'hd759));
        clk = 1'b0;
        arst_n = 1'b0;
        req_valid = 1'b0;
        req = '0;
        rsp_credit = 1'b0;
        bp_mode = 1'b0;
        stall_left = 0;
        sent_cnt = 0;
        credit_cnt = 0;
        rsp_cnt = 0;
        returned_cnt = 0;
        cycle_cnt = 0;
        mismatch_errs = 0;
        other_errs = 0;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        repeat (3) @(posedge clk); // idle, outputs must stay low
        #1;

        for (int a = 0; a < 32; a++) begin
            send_req(shift_pkg::OP_SLL, a, $urandom, "sll");
        end
        for (int a = 0; a < 32; a++) begin
            send_req(shift_pkg::OP_SRL, a, $urandom, "srl");
        end
        for (int a = 0; a < 32; a++) begin
            send_req(shift_pkg::OP_SRA, a, $urandom | 32'h8000_0000, "sra_neg");
        end
        for (int a = 0; a < 32; a++) begin
            send_req(shift_pkg::OP_SRA, a, $urandom & 32'h7fff_ffff, "sra_pos");
        end

        bp_mode = 1'b1;
        for (int n = 0; n < 40; n++) begin
            op = shift_pkg::shift_op_e'($urandom % 3);
            send_req(op, $urandom % 32, $urandom, "backpressure");
        end
        bp_mode = 1'b0;

        while (rsp_cnt < sent_cnt) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        // queue drained, every request gave its credit back
        assert (credit_cnt == sent_cnt)
        else begin
            other_errs++;
            $display("saw %0d upstream credits for %0d requests", credit_cnt, sent_cnt);
        end

        print_error_counts();
        if (mismatch_errs + other_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
common/shift_pkg.sv
shifter/shifter_triangle_8.sv
shifter/shifter_square_8.sv
shifter/shifter_32.sv
rtl/fill_mask_gen.sv
rtl/shift_req_fifo.sv
rtl/shift_merge.sv
rtl/shift_unit.sv
testbench/tb_shift_unit.sv

// File: Bender.yml
package:
  name: shift_unit

sources:
  # package first, then leaf blocks, then the top level
  - files:
      - common/shift_pkg.sv
      - shifter/shifter_triangle_8.sv
      - shifter/shifter_square_8.sv
      - shifter/shifter_32.sv
      - rtl/fill_mask_gen.sv
      - rtl/shift_req_fifo.sv
      - rtl/shift_merge.sv
      - rtl/shift_unit.sv

  # testbench top is tb_shift_unit
  - target: test
    files:
      - testbench/tb_shift_unit.sv
